/* hdl/flit_queue.sv */
// per-input FIFO of NR_QUEUE_DEPTH flits; a full queue refuses pushes even when popped that cycle
`timescale 1ns/1ns
`default_nettype none

`include "noc_router_defines.svh"

module flit_queue
(
	input  logic                         clk,
	input  logic                         reset,
	input  noc_router_pkg::routed_flit_t push_flit,
	input  logic                         push_valid,
	output logic                         push_ready,
	output noc_router_pkg::routed_flit_t head_flit,
	output logic                         head_valid,
	input  logic                         pop
);

	localparam int PTR_W = $clog2(`NR_QUEUE_DEPTH);
	localparam int CNT_W = $clog2(`NR_QUEUE_DEPTH + 1);

	noc_router_pkg::routed_flit_t mem [`NR_QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push_fire;
	logic             pop_fire;

	assign push_ready = (count < CNT_W'(`NR_QUEUE_DEPTH));
	assign head_valid = (count != '0);
	assign head_flit  = mem[rd_ptr];

	assign push_fire = push_valid && push_ready;
	assign pop_fire  = pop && head_valid;

	always_ff @(posedge clk)
	begin
		if (push_fire)
		begin
			mem[wr_ptr] <= push_flit;
		end
	end

	// depth is not a power of two, so pointers wrap explicitly
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_fire)
			begin
				if (wr_ptr == PTR_W'(`NR_QUEUE_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_fire)
			begin
				if (rd_ptr == PTR_W'(`NR_QUEUE_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_fire, pop_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/ingress_stage.sv */
// one-flit input register; route is computed from my_x/my_y at accept time and never recomputed
`timescale 1ns/1ns
`default_nettype none

`include "noc_router_defines.svh"

module ingress_stage
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic [`NR_COORD_W-1:0]       my_x,
	input  logic [`NR_COORD_W-1:0]       my_y,
	input  noc_router_pkg::flit_t        in_flit,
	input  logic                         in_valid,
	output logic                         in_ready,
	output noc_router_pkg::routed_flit_t q_flit,
	output logic                         q_valid,
	input  logic                         q_ready
);

	logic accept;

	// free now, or the held flit moves into the queue this cycle
	assign in_ready = !q_valid || q_ready;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			q_valid <= 1'b0;
		end
		else if (accept)
		begin
			q_valid <= 1'b1;
		end
		else if (q_ready)
		begin
			q_valid <= 1'b0;
		end
	end

	// payload and route tag
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			q_flit.flit  <= in_flit;
			q_flit.route <= noc_router_pkg::route_west_first(my_x, my_y,
				in_flit.dst_x, in_flit.dst_y);
		end
	end

endmodule

`default_nettype wire

/* hdl/noc_router_defines.svh */
// router sizing for a 4x4 mesh only; coordinates must fit NR_COORD_W bits, port count fixed at 5
`ifndef NOC_ROUTER_DEFINES_SVH
`define NOC_ROUTER_DEFINES_SVH

// two bits per coordinate cover a 4x4 mesh
`define NR_COORD_W 2

// payload bits carried by every flit
`define NR_PAYLOAD_W 88

// north, east, south, west, local
`define NR_NUM_PORTS 5

// flits buffered per input queue
`define NR_QUEUE_DEPTH 6

`endif

/* hdl/noc_router_pkg.sv */
// flit layout and west-first routing; port encodings are fixed and must match the mesh wiring
`default_nettype none

`include "noc_router_defines.svh"

package noc_router_pkg;

	// output direction doubles as the port index
	typedef enum logic [2:0]
	{
		PORT_NORTH = 3'd0,
		PORT_EAST  = 3'd1,
		PORT_SOUTH = 3'd2,
		PORT_WEST  = 3'd3,
		PORT_LOCAL = 3'd4
	} port_dir_e;

	// payload on top with source coordinates in the low bits
	typedef struct packed
	{
		logic [`NR_PAYLOAD_W-1:0] payload;
		logic [`NR_COORD_W-1:0]   dst_y;
		logic [`NR_COORD_W-1:0]   dst_x;
		logic [`NR_COORD_W-1:0]   src_y;
		logic [`NR_COORD_W-1:0]   src_x;
	} flit_t;

	// flit tagged with its output port
	typedef struct packed
	{
		port_dir_e route;
		flit_t     flit;
	} routed_flit_t;

	// west moves first, then east, then the y axis
	function automatic port_dir_e route_west_first(
		input logic [`NR_COORD_W-1:0] my_x,
		input logic [`NR_COORD_W-1:0] my_y,
		input logic [`NR_COORD_W-1:0] dst_x,
		input logic [`NR_COORD_W-1:0] dst_y
	);
		port_dir_e dir;
		if (dst_x < my_x)
			dir = PORT_WEST;
		else if (dst_x > my_x)
			dir = PORT_EAST;
		else if (dst_y < my_y)
			dir = PORT_SOUTH;
		else if (dst_y > my_y)
			dir = PORT_NORTH;
		else
			dir = PORT_LOCAL;
		return dir;
	endfunction

endpackage

`default_nettype wire

/* hdl/noc_router_top.sv */
// five-port west-first mesh router; my_x/my_y must be static, each output holds its flit until out_ready
`timescale 1ns/1ns
`default_nettype none

`include "noc_router_defines.svh"

module noc_router_top
(
	input  logic                           clk,
	input  logic                           reset,
	input  logic [`NR_COORD_W-1:0]         my_x,
	input  logic [`NR_COORD_W-1:0]         my_y,
	input  noc_router_pkg::flit_t          in_flit [`NR_NUM_PORTS],
	input  logic [`NR_NUM_PORTS-1:0]       in_valid,
	output logic [`NR_NUM_PORTS-1:0]       in_ready,
	output noc_router_pkg::flit_t          out_flit [`NR_NUM_PORTS],
	output logic [`NR_NUM_PORTS-1:0]       out_valid,
	input  logic [`NR_NUM_PORTS-1:0]       out_ready
);

	// ingress to queue
	noc_router_pkg::routed_flit_t ing_flit [`NR_NUM_PORTS];
	logic [`NR_NUM_PORTS-1:0]     ing_valid;
	logic [`NR_NUM_PORTS-1:0]     ing_ready;

	// queue heads toward the allocator
	noc_router_pkg::routed_flit_t head_flit [`NR_NUM_PORTS];
	logic [`NR_NUM_PORTS-1:0]     head_valid;
	logic [`NR_NUM_PORTS-1:0]     pop;

	// allocator to output registers
	noc_router_pkg::flit_t        load_flit [`NR_NUM_PORTS];
	logic [`NR_NUM_PORTS-1:0]     load_valid;
	logic [`NR_NUM_PORTS-1:0]     load_ready;

	genvar p;
	generate
		for (p = 0; p < `NR_NUM_PORTS; p++)
		begin : g_port
			ingress_stage u_ingress
			(
				.clk      (clk),
				.reset    (reset),
				.my_x     (my_x),
				.my_y     (my_y),
				.in_flit  (in_flit[p]),
				.in_valid (in_valid[p]),
				.in_ready (in_ready[p]),
				.q_flit   (ing_flit[p]),
				.q_valid  (ing_valid[p]),
				.q_ready  (ing_ready[p])
			);

			flit_queue u_queue
			(
				.clk        (clk),
				.reset      (reset),
				.push_flit  (ing_flit[p]),
				.push_valid (ing_valid[p]),
				.push_ready (ing_ready[p]),
				.head_flit  (head_flit[p]),
				.head_valid (head_valid[p]),
				.pop        (pop[p])
			);

			output_stage u_output
			(
				.clk        (clk),
				.reset      (reset),
				.load_flit  (load_flit[p]),
				.load_valid (load_valid[p]),
				.load_ready (load_ready[p]),
				.out_flit   (out_flit[p]),
				.out_valid  (out_valid[p]),
				.out_ready  (out_ready[p])
			);
		end
	endgenerate

	// one allocator serves all five outputs
	switch_allocator u_alloc
	(
		.clk        (clk),
		.reset      (reset),
		.head_flit  (head_flit),
		.head_valid (head_valid),
		.pop        (pop),
		.load_flit  (load_flit),
		.load_valid (load_valid),
		.load_ready (load_ready)
	);

endmodule

`default_nettype wire

/* hdl/output_stage.sv */
// one-flit output register; out_flit is held stable until out_ready, reload allowed in the leaving cycle
`timescale 1ns/1ns
`default_nettype none

module output_stage
(
	input  logic                  clk,
	input  logic                  reset,
	input  noc_router_pkg::flit_t load_flit,
	input  logic                  load_valid,
	output logic                  load_ready,
	output noc_router_pkg::flit_t out_flit,
	output logic                  out_valid,
	input  logic                  out_ready
);

	logic load_fire;

	// empty, or current flit leaves this cycle
	assign load_ready = !out_valid || out_ready;
	assign load_fire  = load_valid && load_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
		end
		else if (load_fire)
		begin
			out_valid <= 1'b1;
		end
		else if (out_ready)
		begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load_fire)
		begin
			out_flit <= load_flit;
		end
	end

endmodule

`default_nettype wire

/* hdl/switch_allocator.sv */
// round-robin per output over queue heads; an input only ever requests the output its head routes to
`timescale 1ns/1ns
`default_nettype none

`include "noc_router_defines.svh"

module switch_allocator
(
	input  logic                         clk,
	input  logic                         reset,
	input  noc_router_pkg::routed_flit_t head_flit [`NR_NUM_PORTS],
	input  logic [`NR_NUM_PORTS-1:0]     head_valid,
	output logic [`NR_NUM_PORTS-1:0]     pop,
	output noc_router_pkg::flit_t        load_flit [`NR_NUM_PORTS],
	output logic [`NR_NUM_PORTS-1:0]     load_valid,
	input  logic [`NR_NUM_PORTS-1:0]     load_ready
);

	localparam int N     = `NR_NUM_PORTS;
	localparam int PTR_W = $clog2(N);

	// indexed [output][input]
	logic [N-1:0]     req   [N];
	logic [N-1:0]     grant [N];
	// last input granted, per output
	logic [PTR_W-1:0] rr_ptr [N];

	always_comb
	begin
		for (int o = 0; o < N; o++)
		begin
			for (int i = 0; i < N; i++)
			begin
				req[o][i] = head_valid[i] &&
					(head_flit[i].route == noc_router_pkg::port_dir_e'(o));
			end
		end
	end

	// search starts just after the last winner
	always_comb
	begin
		int  idx;
		logic found;
		for (int o = 0; o < N; o++)
		begin
			grant[o] = '0;
			found    = 1'b0;
			for (int k = 1; k <= N; k++)
			begin
				idx = (int'(rr_ptr[o]) + k) % N;
				if (!found && req[o][idx] && load_ready[o])
				begin
					grant[o][idx] = 1'b1;
					found         = 1'b1;
				end
			end
		end
	end

	// crossbar drops the route tag
	always_comb
	begin
		pop = '0;
		for (int o = 0; o < N; o++)
		begin
			load_flit[o]  = '0;
			load_valid[o] = |grant[o];
			for (int i = 0; i < N; i++)
			begin
				if (grant[o][i])
				begin
					load_flit[o] = head_flit[i].flit;
					pop[i]       = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// local as last winner so north goes first
			for (int o = 0; o < N; o++)
				rr_ptr[o] <= PTR_W'(noc_router_pkg::PORT_LOCAL);
		end
		else
		begin
			for (int o = 0; o < N; o++)
			begin
				for (int i = 0; i < N; i++)
				begin
					if (grant[o][i])
						rr_ptr[o] <= PTR_W'(i);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/noc_router_pkg.sv
hdl/ingress_stage.sv
hdl/flit_queue.sv
hdl/switch_allocator.sv
hdl/output_stage.sv
hdl/noc_router_top.sv
verif/noc_router_assertions.sv
verif/noc_router_tb.sv

/* verif/noc_router_assertions.sv */
// watches top-level ports only; assumes static my_x/my_y, fail_count is read by the testbench
`timescale 1ns/1ns
`default_nettype none

`include "noc_router_defines.svh"

module noc_router_assertions
(
	input logic                     clk,
	input logic                     reset,
	input logic [`NR_COORD_W-1:0]   my_x,
	input logic [`NR_COORD_W-1:0]   my_y,
	input logic [`NR_NUM_PORTS-1:0] in_ready,
	input noc_router_pkg::flit_t    out_flit [`NR_NUM_PORTS],
	input logic [`NR_NUM_PORTS-1:0] out_valid,
	input logic [`NR_NUM_PORTS-1:0] out_ready
);

	int fail_count = 0;

	// port order north, east, south, west, local
	function automatic logic dest_matches(input int p,
		input logic [`NR_COORD_W-1:0] mx, input logic [`NR_COORD_W-1:0] my,
		input logic [`NR_COORD_W-1:0] dx, input logic [`NR_COORD_W-1:0] dy);
		case (p)
			0:       return (dx == mx) && (dy > my);
			1:       return dx > mx;
			2:       return (dx == mx) && (dy < my);
			3:       return dx < mx;
			default: return (dx == mx) && (dy == my);
		endcase
	endfunction

	ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> &in_ready)
	else
	begin
		$error("in_ready not high on every input after reset");
		fail_count++;
	end

	genvar p;
	generate
		for (p = 0; p < `NR_NUM_PORTS; p++)
		begin : g_port
			hold_flit: assert property (@(posedge clk) disable iff (reset)
				out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_flit[p]))
			else
			begin
				$error("output %0d dropped or changed its flit under back-pressure", p);
				fail_count++;
			end

			right_port: assert property (@(posedge clk) disable iff (reset)
				out_valid[p] |-> dest_matches(p, my_x, my_y, out_flit[p].dst_x,
				out_flit[p].dst_y))
			else
			begin
				$error("output %0d carries a flit addressed elsewhere", p);
				fail_count++;
			end
		end
	endgenerate

endmodule

bind noc_router_top noc_router_assertions u_assertions
(
	.clk       (clk),
	.reset     (reset),
	.my_x      (my_x),
	.my_y      (my_y),
	.in_ready  (in_ready),
	.out_flit  (out_flit),
	.out_valid (out_valid),
	.out_ready (out_ready)
);

`default_nettype wire

/* verif/noc_router_tb.sv */
// router at (1,2); src coords of each flit name its input port, needs a simulator with timing
`timescale 1ns/1ns
`default_nettype none

`include "noc_router_defines.svh"

module noc_router_tb;

	localparam int N = `NR_NUM_PORTS;
	localparam logic [`NR_COORD_W-1:0] MY_X = 1;
	localparam logic [`NR_COORD_W-1:0] MY_Y = 2;
	localparam int P_NORTH = 0;
	localparam int P_EAST  = 1;
	localparam int P_SOUTH = 2;
	localparam int P_WEST  = 3;
	localparam int P_LOCAL = 4;
	// flits one input can hold in its output register, queue and ingress register
	localparam int CAPACITY = `NR_QUEUE_DEPTH + 2;
	// coordinates of the neighbour behind each input
	localparam int SRC_X [N] = '{1, 2, 1, 0, 1};
	localparam int SRC_Y [N] = '{3, 2, 1, 2, 2};

	typedef struct
	{
		string name;
		int    port;
		int    dst_x;
		int    dst_y;
		int    count;
		bit    hold;
		bit    alt;
	} entry_t;

	logic                  clk;
	logic                  reset;
	noc_router_pkg::flit_t in_flit [N];
	logic [N-1:0]          in_valid;
	logic [N-1:0]          in_ready;
	noc_router_pkg::flit_t out_flit [N];
	logic [N-1:0]          out_valid;
	logic [N-1:0]          out_ready;
	logic [N-1:0]          acc_q;

	entry_t                table_q [$];
	noc_router_pkg::flit_t exp_q [N][$];
	int    table_size = 0;
	int    seed;
	int    outstanding = 0;
	int    errors = 0;
	int    checks = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    last_src [N];
	int    arrivals [N];
	string cur_name;
	bit    cur_alt;

	noc_router_top u_dut
	(
		.clk       (clk),
		.reset     (reset),
		.my_x      (MY_X),
		.my_y      (MY_Y),
		.in_flit   (in_flit),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_flit  (out_flit),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	always #4 clk = ~clk;

	// input transfers seen at the last rising edge
	always @(posedge clk)
	begin
		acc_q <= in_valid & in_ready;
	end

	function automatic int expected_port(input int dx, input int dy);
		if (dx < MY_X)
			return P_WEST;
		if (dx > MY_X)
			return P_EAST;
		if (dy < MY_Y)
			return P_SOUTH;
		if (dy > MY_Y)
			return P_NORTH;
		return P_LOCAL;
	endfunction

	function automatic int source_port(input noc_router_pkg::flit_t f);
		int src;
		src = -1;
		for (int p = 0; p < N; p++)
		begin
			if (f.src_x == SRC_X[p] && f.src_y == SRC_Y[p])
				src = p;
		end
		return src;
	endfunction

	task automatic add_entry(input string name, input int port, input int dx, input int dy,
		input int count, input bit hold, input bit alt);
		entry_t e;
		e.name  = name;
		e.port  = port;
		e.dst_x = dx;
		e.dst_y = dy;
		e.count = count;
		e.hold  = hold;
		e.alt   = alt;
		table_q.push_back(e);
	endtask

	// oldest expected flit from the same input must match
	task automatic check_arrival(input int p, input noc_router_pkg::flit_t got);
		int                    src;
		int                    idx;
		int                    want_src;
		noc_router_pkg::flit_t want;
		src = source_port(got);
		idx = -1;
		for (int i = exp_q[p].size() - 1; i >= 0; i--)
		begin
			if (source_port(exp_q[p][i]) == src)
				idx = i;
		end
		checks++;
		assert (idx >= 0)
		else
		begin
			$display("%s: output %0d delivered flit %h that nobody sent there", cur_name, p, got);
			errors++;
		end
		if (idx >= 0)
		begin
			want = exp_q[p][idx];
			exp_q[p].delete(idx);
			outstanding--;
			assert (got == want)
			else
			begin
				$display("CHECK FAILED: %s output %0d expected %h actual %h",
					cur_name, p, want, got);
				errors++;
			end
		end
		if (cur_alt)
		begin
			// two sources, north first, then strictly taking turns
			want_src = (arrivals[p] == 0 || last_src[p] != P_NORTH) ? P_NORTH : P_SOUTH;
			assert (src == want_src)
			else
			begin
				$display("CHECK FAILED: %s output %0d source expected %0d actual %0d",
					cur_name, p, want_src, src);
				errors++;
			end
			last_src[p] = src;
			arrivals[p]++;
		end
	endtask

	always @(posedge clk)
	begin
		if (!reset)
		begin
			for (int p = 0; p < N; p++)
			begin
				if (out_valid[p] && out_ready[p])
					check_arrival(p, out_flit[p]);
			end
		end
	end

	task automatic run_test(input int first, input int last);
		noc_router_pkg::flit_t send_q [N][$];
		noc_router_pkg::flit_t f;
		int sent [N];
		int pending;
		int errors_before;
		int port;
		cur_name      = table_q[first].name;
		cur_alt       = table_q[first].alt;
		errors_before = errors;
		pending       = 0;
		for (int p = 0; p < N; p++)
		begin
			sent[p]     = 0;
			arrivals[p] = 0;
		end
		for (int e = first; e <= last; e++)
		begin
			for (int n = 0; n < table_q[e].count; n++)
			begin
				port      = table_q[e].port;
				f.payload = `NR_PAYLOAD_W'({$random(seed), $random(seed), $random(seed)});
				f.dst_x   = `NR_COORD_W'(table_q[e].dst_x);
				f.dst_y   = `NR_COORD_W'(table_q[e].dst_y);
				f.src_x   = `NR_COORD_W'(SRC_X[port]);
				f.src_y   = `NR_COORD_W'(SRC_Y[port]);
				send_q[port].push_back(f);
				exp_q[expected_port(table_q[e].dst_x, table_q[e].dst_y)].push_back(f);
				outstanding++;
				pending++;
				sent[port]++;
			end
		end
		@(negedge clk);
		out_ready = table_q[first].hold ? '0 : '1;
		// all inputs stream in parallel, each in its own order
		while (pending > 0)
		begin
			@(negedge clk);
			for (int p = 0; p < N; p++)
			begin
				if (in_valid[p] && acc_q[p])
				begin
					send_q[p].delete(0);
					in_valid[p] = 1'b0;
					pending--;
				end
				if (!in_valid[p] && send_q[p].size() > 0)
				begin
					in_flit[p]  = send_q[p][0];
					in_valid[p] = 1'b1;
				end
			end
		end
		if (table_q[first].hold)
		begin
			repeat (2) @(negedge clk);
			for (int p = 0; p < N; p++)
			begin
				assert (sent[p] == 0 || in_ready[p] == (sent[p] < CAPACITY))
				else
				begin
					$display("CHECK FAILED: %s in_ready[%0d] expected %0b actual %0b",
						cur_name, p, sent[p] < CAPACITY, in_ready[p]);
					errors++;
				end
			end
			out_ready = '1;
		end
		while (outstanding > 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
		assert (in_ready == '1)
		else
		begin
			$display("%s: in_ready did not return high on every input", cur_name);
			errors++;
		end
		tests_run++;
		if (errors != errors_before)
			tests_failed++;
		$display("%s: done, %0d errors", cur_name, errors - errors_before);
	endtask

	initial
	begin
		int first;
		int last;
		clk       = 1'b0;
		reset     = 1'b1;
		seed      = 32'h61ca3c4e;
		in_valid  = '0;
		out_ready = '1;
		for (int p = 0; p < N; p++)
			in_flit[p] = '0;
		for (int x = 0; x < 4; x++)
		begin
			for (int y = 0; y < 4; y++)
				add_entry("routing", P_LOCAL, x, y, 1, 1'b0, 1'b0);
		end
		add_entry("east_first", P_WEST, 2, 0, 1, 1'b0, 1'b0);
		add_entry("east_first", P_WEST, 2, 1, 1, 1'b0, 1'b0);
		add_entry("east_first", P_WEST, 2, 3, 1, 1'b0, 1'b0);
		add_entry("east_first", P_WEST, 3, 0, 1, 1'b0, 1'b0);
		add_entry("east_first", P_WEST, 3, 1, 1, 1'b0, 1'b0);
		add_entry("east_first", P_WEST, 3, 3, 1, 1'b0, 1'b0);
		// kept off the west output so its round-robin pointer still rests on local
		add_entry("order_burst", P_EAST, 1, 0, 10, 1'b0, 1'b0);
		add_entry("back_pressure", P_NORTH, 1, 0, CAPACITY, 1'b1, 1'b0);
		add_entry("fairness", P_NORTH, 0, 2, 4, 1'b1, 1'b1);
		add_entry("fairness", P_SOUTH, 0, 0, 4, 1'b1, 1'b1);
		add_entry("concurrency", P_NORTH, 1, 0, 3, 1'b0, 1'b0);
		add_entry("concurrency", P_EAST, 0, 2, 3, 1'b0, 1'b0);
		add_entry("concurrency", P_SOUTH, 1, 3, 3, 1'b0, 1'b0);
		add_entry("concurrency", P_WEST, 3, 2, 3, 1'b0, 1'b0);
		add_entry("concurrency", P_LOCAL, 1, 2, 3, 1'b0, 1'b0);
		table_size = table_q.size();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		first = 0;
		while (first < table_size)
		begin
			last = first;
			while (last + 1 < table_size && table_q[last + 1].name == table_q[first].name)
				last++;
			run_test(first, last);
			first = last + 1;
		end
		$display("tests %0d, failed %0d, flit checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, u_dut.u_assertions.fail_count);
		if (errors == 0 && u_dut.u_assertions.fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// 200 cycles per table entry
	initial
	begin
		wait (table_size > 0);
		repeat (table_size * 200) @(posedge clk);
		$display("watchdog: the router stopped delivering flits, %0d still outstanding in %s",
			outstanding, cur_name);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
